//--- rtl/cw_pkg.sv
package cw_pkg;

	// register bus widths
	localparam int CW_ADDR_W = 6;
	localparam int CW_DATA_W = 8;
	localparam int CW_CNT_W  = 16;

	typedef logic [CW_ADDR_W-1:0] cw_addr_t;   // register address
	typedef logic [CW_DATA_W-1:0] cw_byte_t;   // one data byte
	typedef logic [CW_CNT_W-1:0]  cw_cnt_t;    // byte count or length

	// register map
	localparam cw_addr_t CW_TRIGSRC_ADDR = 6'd39;
	localparam cw_addr_t CW_TRIGMOD_ADDR = 6'd40;
	localparam cw_addr_t CW_IOROUTE_ADDR = 6'd55;

	localparam int CW_IOROUTE_BYTES = 8;                          // routing register length
	localparam int CW_BYTESEL_W     = $clog2(CW_IOROUTE_BYTES);   // bytecnt bits that pick a byte
	localparam int CW_NUM_GPIO      = 3;                          // GPIO1..GPIO3 are routed
	localparam int CW_USOC_PIN      = 2;                          // GPIO3 has the open collector mode

	typedef logic [CW_IOROUTE_BYTES*CW_DATA_W-1:0] cw_ioroute_t;  // all routing bytes

	// trigger source register
	// bits 5:0 enable front A, front B, IO1, IO2, IO3, IO4
	localparam int TRIGSRC_MASK_W   = 6;
	localparam int TRIGSRC_MODE_LSB = 6;
	localparam int TRIGSRC_MODE_W   = 2;

	localparam logic [TRIGSRC_MODE_W-1:0] COMBINE_OR  = 2'd0;
	localparam logic [TRIGSRC_MODE_W-1:0] COMBINE_AND = 2'd1;
	// modes 2 and 3 are reserved and give no trigger

	// trigger module register
	// bits 4:3 are kept for readback only
	localparam int TRIGMOD_SEL_W = 3;

	localparam logic [TRIGMOD_SEL_W-1:0] TRIGMOD_EDGE   = 3'd0;  // combined external trigger
	localparam logic [TRIGMOD_SEL_W-1:0] TRIGMOD_ADVIO  = 3'd1;  // advanced IO pattern
	localparam logic [TRIGMOD_SEL_W-1:0] TRIGMOD_ANAPAT = 3'd2;  // analog pattern match

	// bit positions inside each pin's routing byte
	localparam int ROUTE_TX      = 0;   // drive uart tx
	localparam int ROUTE_RX      = 1;   // pin feeds uart rx
	localparam int ROUTE_USIO    = 2;   // drive usi out
	localparam int ROUTE_USII    = 3;   // pin feeds usi in
	localparam int ROUTE_USOC    = 4;   // usi out as open collector
	localparam int ROUTE_LEVEL   = 6;   // static level when gpio enabled
	localparam int ROUTE_GPIO_EN = 7;   // static gpio drive enable

	// reset values
	localparam cw_byte_t TRIGSRC_RESET = 8'h01;   // front A alone, OR mode
	localparam cw_byte_t TRIGMOD_RESET = 8'h00;   // edge trigger

	// byte 0 puts TX on GPIO1, byte 1 puts RX on GPIO2
	localparam cw_ioroute_t IOROUTE_RESET = 64'h0000_0000_0000_0201;

	// byte 4 holds the glitch output bits which are stored only
	// bytes 5 to 7 are reserved

endpackage

//--- rtl/cw_regfile.sv
`timescale 1ns/1ps

module cw_regfile (
	input  logic               clk,
	input  logic               reset,
	input  cw_pkg::cw_addr_t   reg_address_i,     // register being accessed
	input  cw_pkg::cw_cnt_t    reg_bytecnt_i,     // byte index within a register
	input  cw_pkg::cw_byte_t   reg_datai_i,       // write data
	input  logic               reg_read_i,        // read strobe
	input  logic               reg_write_i,       // write strobe
	input  logic               reg_addrvalid_i,   // address qualifier for readback
	input  cw_pkg::cw_addr_t   reg_hypaddress_i,  // address for length lookup
	output cw_pkg::cw_byte_t   reg_datao_o,       // registered read data
	output cw_pkg::cw_cnt_t    reg_hyplen_o,      // length of reg_hypaddress_i
	output cw_pkg::cw_byte_t   trigsrc_o,
	output cw_pkg::cw_byte_t   trigmod_o,
	output cw_pkg::cw_ioroute_t ioroute_o
);
	import cw_pkg::*;

	cw_byte_t    trigsrc_q;    // input mask and combine mode
	cw_byte_t    trigmod_q;    // capture trigger source
	cw_ioroute_t ioroute_q;    // eight routing bytes
	cw_byte_t    rdata_q;      // byte captured on a read strobe
	logic        rvalid_q;     // read data qualifier

	logic [CW_BYTESEL_W-1:0] byte_sel;
	logic                    addr_known;

	// only the low bytecnt bits pick a routing byte
	assign byte_sel = reg_bytecnt_i[CW_BYTESEL_W-1:0];

	// one of our three registers is addressed
	always_comb begin
		case (reg_address_i)
			CW_TRIGSRC_ADDR,
			CW_TRIGMOD_ADDR,
			CW_IOROUTE_ADDR: addr_known = 1'b1;
			default:         addr_known = 1'b0;
		endcase
	end

	// configuration registers
	always_ff @(posedge clk) begin
		if (reset) begin
			trigsrc_q <= TRIGSRC_RESET;
			trigmod_q <= TRIGMOD_RESET;
			ioroute_q <= IOROUTE_RESET;
		end else if (reg_write_i) begin
			case (reg_address_i)
				CW_TRIGSRC_ADDR: trigsrc_q <= reg_datai_i;
				CW_TRIGMOD_ADDR: trigmod_q <= reg_datai_i;
				CW_IOROUTE_ADDR: ioroute_q[byte_sel*CW_DATA_W +: CW_DATA_W] <= reg_datai_i;
				default: ;  // writes elsewhere are dropped
			endcase
		end
	end

	// valid follows the address phase, independent of the read strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= reg_addrvalid_i & addr_known;
		end
	end

	// read capture
	always_ff @(posedge clk) begin
		if (reg_read_i) begin
			case (reg_address_i)
				CW_TRIGSRC_ADDR: rdata_q <= trigsrc_q;
				CW_TRIGMOD_ADDR: rdata_q <= trigmod_q;
				CW_IOROUTE_ADDR: rdata_q <= ioroute_q[byte_sel*CW_DATA_W +: CW_DATA_W];
				default:         rdata_q <= '0;
			endcase
		end
	end

	assign reg_datao_o = rvalid_q ? rdata_q : '0;  // bus reads 0 unless qualified

	// register length lookup for the host
	always_comb begin
		case (reg_hypaddress_i)
			CW_TRIGSRC_ADDR: reg_hyplen_o = cw_cnt_t'(1);
			CW_TRIGMOD_ADDR: reg_hyplen_o = cw_cnt_t'(1);
			CW_IOROUTE_ADDR: reg_hyplen_o = cw_cnt_t'(CW_IOROUTE_BYTES);
			default:         reg_hyplen_o = '0;
		endcase
	end

	assign trigsrc_o = trigsrc_q;
	assign trigmod_o = trigmod_q;
	assign ioroute_o = ioroute_q;

	// host never reads and writes in the same cycle
	a_rd_wr_excl: assert property (
		@(posedge clk) disable iff (reset)
		!(reg_read_i && reg_write_i)
	);

	// a qualified address is fully driven
	a_addr_known: assert property (
		@(posedge clk) disable iff (reset)
		reg_addrvalid_i |-> !$isunknown(reg_address_i)
	);

endmodule

//--- rtl/trig_combine.sv
`timescale 1ns/1ps

module trig_combine (
	input  cw_pkg::cw_byte_t trigsrc_i,          // mask and combine mode
	input  cw_pkg::cw_byte_t trigmod_i,          // trigger module select
	input  logic             trig_fpa_i,         // front panel A
	input  logic             trig_fpb_i,         // front panel B
	input  logic             trig_io1_i,
	input  logic             trig_io2_i,
	input  logic             trig_io3_i,
	input  logic             trig_io4_i,
	input  logic             trig_advio_i,       // advanced IO pattern trigger
	input  logic             trig_anapattern_i,  // analog pattern trigger
	output logic             trigger_ext_o,      // combined external trigger
	output logic             trigger_o           // capture trigger
);
	import cw_pkg::*;

	logic [TRIGSRC_MASK_W-1:0] trig_vec;    // inputs in mask bit order
	logic [TRIGSRC_MASK_W-1:0] trig_mask;
	logic [TRIGSRC_MODE_W-1:0] comb_mode;
	logic [TRIGMOD_SEL_W-1:0]  mod_sel;
	logic                      trig_or;
	logic                      trig_and;

	assign trig_vec  = {trig_io4_i, trig_io3_i, trig_io2_i, trig_io1_i, trig_fpb_i, trig_fpa_i};
	assign trig_mask = trigsrc_i[TRIGSRC_MASK_W-1:0];
	assign comb_mode = trigsrc_i[TRIGSRC_MODE_LSB +: TRIGSRC_MODE_W];
	assign mod_sel   = trigmod_i[TRIGMOD_SEL_W-1:0];

	assign trig_or  = |(trig_vec & trig_mask);   // empty mask gives 0
	assign trig_and = &(trig_vec | ~trig_mask);  // disabled inputs count as high

	always_comb begin
		case (comb_mode)
			COMBINE_OR:  trigger_ext_o = trig_or;
			COMBINE_AND: trigger_ext_o = trig_and;
			default:     trigger_ext_o = 1'b0;  // reserved modes
		endcase
	end

	// capture trigger source
	always_comb begin
		case (mod_sel)
			TRIGMOD_EDGE:   trigger_o = trigger_ext_o;
			TRIGMOD_ADVIO:  trigger_o = trig_advio_i;
			TRIGMOD_ANAPAT: trigger_o = trig_anapattern_i;
			default:        trigger_o = 1'b0;
		endcase
	end

	// X on the capture trigger only comes from the selected source
	a_trig_known: assert final (
		$isunknown(mod_sel) ||
		(mod_sel == TRIGMOD_EDGE && $isunknown({trigsrc_i, trig_vec})) ||
		(mod_sel == TRIGMOD_ADVIO && $isunknown(trig_advio_i)) ||
		(mod_sel == TRIGMOD_ANAPAT && $isunknown(trig_anapattern_i)) ||
		!$isunknown(trigger_o)
	);

endmodule

//--- rtl/target_io_route.sv
`timescale 1ns/1ps

module target_io_route (
	input  cw_pkg::cw_ioroute_t            ioroute_i,   // routing bytes from the regfile
	input  logic                           uart_tx_i,   // uart tx toward the target
	input  logic                           usi_out_i,   // usi data toward the target
	input  logic [cw_pkg::CW_NUM_GPIO-1:0] gpio_i,      // pin input levels
	output logic [cw_pkg::CW_NUM_GPIO-1:0] gpio_o,      // pin drive levels
	output logic [cw_pkg::CW_NUM_GPIO-1:0] gpio_oe_o,   // pin drive enables
	output logic                           uart_rx_o,   // uart rx from the target
	output logic                           usi_in_o     // usi data from the target
);
	import cw_pkg::*;

	// one routing byte per routed pin, byte 0 is GPIO1
	logic [CW_NUM_GPIO-1:0][CW_DATA_W-1:0] pin_route;

	assign pin_route = ioroute_i[CW_NUM_GPIO*CW_DATA_W-1:0];

	// output drive, first matching bit wins
	always_comb begin
		gpio_o    = '0;
		gpio_oe_o = '0;
		for (int i = 0; i < CW_NUM_GPIO; i++) begin
			if (pin_route[i][ROUTE_TX]) begin
				gpio_oe_o[i] = 1'b1;
				gpio_o[i]    = uart_tx_i;
			end else if (pin_route[i][ROUTE_USIO]) begin
				gpio_oe_o[i] = 1'b1;
				gpio_o[i]    = usi_out_i;
			end else if (i == CW_USOC_PIN && pin_route[i][ROUTE_USOC]) begin
				// open collector, pull low on a 0 and float on a 1
				gpio_oe_o[i] = ~usi_out_i;
				gpio_o[i]    = 1'b0;
			end else if (pin_route[i][ROUTE_GPIO_EN]) begin
				gpio_oe_o[i] = 1'b1;
				gpio_o[i]    = pin_route[i][ROUTE_LEVEL];  // static level
			end
		end
	end

	// input select, walk down so the lowest pin wins
	always_comb begin
		uart_rx_o = 1'b1;  // idle high when no pin selected
		usi_in_o  = 1'b1;
		for (int i = CW_NUM_GPIO - 1; i >= 0; i--) begin
			if (pin_route[i][ROUTE_RX]) begin
				uart_rx_o = gpio_i[i];
			end
			if (pin_route[i][ROUTE_USII]) begin
				usi_in_o = gpio_i[i];
			end
		end
	end

	// enables settle once routing and usi out are driven
	a_oe_known: assert final (
		$isunknown({ioroute_i, usi_out_i}) || !$isunknown(gpio_oe_o)
	);

endmodule

//--- rtl/cw_route_top.sv
`timescale 1ns/1ps

module cw_route_top (
	input  logic                           clk,
	input  logic                           reset,
	// register bus
	input  cw_pkg::cw_addr_t               reg_address_i,
	input  cw_pkg::cw_cnt_t                reg_bytecnt_i,
	input  cw_pkg::cw_byte_t               reg_datai_i,
	input  logic                           reg_read_i,
	input  logic                           reg_write_i,
	input  logic                           reg_addrvalid_i,
	input  cw_pkg::cw_addr_t               reg_hypaddress_i,
	output cw_pkg::cw_byte_t               reg_datao_o,
	output cw_pkg::cw_cnt_t                reg_hyplen_o,
	// trigger pins
	input  logic                           trig_fpa_i,
	input  logic                           trig_fpb_i,
	input  logic                           trig_io1_i,
	input  logic                           trig_io2_i,
	input  logic                           trig_io3_i,
	input  logic                           trig_io4_i,
	input  logic                           trig_advio_i,
	input  logic                           trig_anapattern_i,
	output logic                           trigger_ext_o,
	output logic                           trigger_o,
	// target serial lines and GPIO
	input  logic                           uart_tx_i,
	input  logic                           usi_out_i,
	input  logic [cw_pkg::CW_NUM_GPIO-1:0] gpio_i,
	output logic [cw_pkg::CW_NUM_GPIO-1:0] gpio_o,
	output logic [cw_pkg::CW_NUM_GPIO-1:0] gpio_oe_o,
	output logic                           uart_rx_o,
	output logic                           usi_in_o
);
	import cw_pkg::*;

	cw_byte_t    trigsrc;   // trigger source register
	cw_byte_t    trigmod;   // trigger module register
	cw_ioroute_t ioroute;   // gpio routing register

	cw_regfile u_cw_regfile (
		.clk              (clk),
		.reset            (reset),
		.reg_address_i    (reg_address_i),
		.reg_bytecnt_i    (reg_bytecnt_i),
		.reg_datai_i      (reg_datai_i),
		.reg_read_i       (reg_read_i),
		.reg_write_i      (reg_write_i),
		.reg_addrvalid_i  (reg_addrvalid_i),
		.reg_hypaddress_i (reg_hypaddress_i),
		.reg_datao_o      (reg_datao_o),
		.reg_hyplen_o     (reg_hyplen_o),
		.trigsrc_o        (trigsrc),
		.trigmod_o        (trigmod),
		.ioroute_o        (ioroute)
	);

	trig_combine u_trig_combine (
		.trigsrc_i         (trigsrc),
		.trigmod_i         (trigmod),
		.trig_fpa_i        (trig_fpa_i),
		.trig_fpb_i        (trig_fpb_i),
		.trig_io1_i        (trig_io1_i),
		.trig_io2_i        (trig_io2_i),
		.trig_io3_i        (trig_io3_i),
		.trig_io4_i        (trig_io4_i),
		.trig_advio_i      (trig_advio_i),
		.trig_anapattern_i (trig_anapattern_i),
		.trigger_ext_o     (trigger_ext_o),
		.trigger_o         (trigger_o)
	);

	target_io_route u_target_io_route (
		.ioroute_i (ioroute),
		.uart_tx_i (uart_tx_i),
		.usi_out_i (usi_out_i),
		.gpio_i    (gpio_i),
		.gpio_o    (gpio_o),
		.gpio_oe_o (gpio_oe_o),
		.uart_rx_o (uart_rx_o),
		.usi_in_o  (usi_in_o)
	);

endmodule

//--- dv/cw_route_tb_tasks.svh
// one register write whose shadow copy follows on the write edge
task automatic bus_write(input cw_addr_t addr, input cw_cnt_t cnt, input cw_byte_t data);
	@(posedge clk);
	reg_address_i <= addr;
	reg_bytecnt_i <= cnt;
	reg_datai_i   <= data;
	reg_write_i   <= 1'b1;
	@(posedge clk);  // write edge
	reg_write_i <= 1'b0;
	case (addr)
		CW_TRIGSRC_ADDR: shadow_trigsrc <= data;
		CW_TRIGMOD_ADDR: shadow_trigmod <= data;
		CW_IOROUTE_ADDR: shadow_ioroute[cnt[2:0]*8 +: 8] <= data;
		default: ;
	endcase
endtask

// one read strobe with its data checked a cycle later through rd_chk_q
task automatic bus_read(input cw_addr_t addr, input cw_cnt_t cnt, input logic valid);
	@(posedge clk);
	reg_address_i   <= addr;
	reg_bytecnt_i   <= cnt;
	reg_read_i      <= 1'b1;
	reg_addrvalid_i <= valid;
	@(posedge clk);
	reg_read_i      <= 1'b0;
	reg_addrvalid_i <= 1'b0;
endtask

// closing line of a test
task automatic test_done(input string name);
	int errs;
	repeat (2) @(posedge clk);  // let the last read check land
	errs     = err_cnt - err_mark;
	err_mark = err_cnt;
	test_cnt++;
	$display("test %-9s %s, %0d errors", name, (errs == 0) ? "ok" : "FAIL", errs);
endtask

//--- dv/cw_route_tb.sv
`timescale 1ns/1ps

module cw_route_tb;
	import cw_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYC  = 16;
	localparam int TOTAL_CYC  = RESET_CYC + 60 + 100 + 30 + 250 + 320;  // padded per-test budgets

	logic clk = 1'b0;
	logic reset;
	cw_addr_t reg_address_i;
	cw_cnt_t reg_bytecnt_i;
	cw_byte_t reg_datai_i;
	logic reg_read_i;
	logic reg_write_i;
	logic reg_addrvalid_i;
	cw_addr_t reg_hypaddress_i;
	cw_byte_t reg_datao_o;
	cw_cnt_t reg_hyplen_o;
	logic trig_fpa_i, trig_fpb_i, trig_io1_i, trig_io2_i, trig_io3_i, trig_io4_i;
	logic trig_advio_i;
	logic trig_anapattern_i;
	logic trigger_ext_o;
	logic trigger_o;
	logic uart_tx_i;
	logic usi_out_i;
	logic [CW_NUM_GPIO-1:0] gpio_i;
	logic [CW_NUM_GPIO-1:0] gpio_o;
	logic [CW_NUM_GPIO-1:0] gpio_oe_o;
	logic uart_rx_o;
	logic usi_in_o;

	cw_byte_t shadow_trigsrc;     // reference copies of the registers
	cw_byte_t shadow_trigmod;
	cw_ioroute_t shadow_ioroute;
	logic exp_trig_ext;
	logic exp_trig;
	logic [2:0] exp_gpio;
	logic [2:0] exp_gpio_oe;
	logic exp_uart_rx;
	logic exp_usi_in;
	cw_cnt_t exp_hyplen;
	logic rd_chk_q;               // read data is checked this cycle
	cw_byte_t rd_exp_q;
	int err_cnt, err_mark, test_cnt;

	cw_route_top u_cw_route_top (.*);

	always #2 clk = ~clk;

	`include "cw_route_tb_tasks.svh"

	function automatic logic addr_known(input cw_addr_t a);
		return a == CW_TRIGSRC_ADDR || a == CW_TRIGMOD_ADDR || a == CW_IOROUTE_ADDR;
	endfunction

	function automatic cw_addr_t unknown_addr();
		cw_addr_t a;
		a = cw_addr_t'($urandom);
		while (addr_known(a)) a = cw_addr_t'($urandom);
		return a;
	endfunction

	function automatic cw_byte_t shadow_byte(input cw_addr_t a, input cw_cnt_t cnt);
		if (a == CW_TRIGSRC_ADDR) return shadow_trigsrc;
		if (a == CW_TRIGMOD_ADDR) return shadow_trigmod;
		return shadow_ioroute[cnt[2:0]*8 +: 8];
	endfunction

	function automatic cw_cnt_t hyplen_model(input cw_addr_t a);
		if (a == CW_TRIGSRC_ADDR || a == CW_TRIGMOD_ADDR) return 16'd1;
		return (a == CW_IOROUTE_ADDR) ? 16'd8 : 16'd0;
	endfunction

	// count enabled inputs by level, then apply the combine mode
	function automatic logic ext_model(input cw_byte_t src, input logic [5:0] lvl);
		int n_hi;
		int n_lo;
		n_hi = 0;
		n_lo = 0;
		for (int b = 0; b < 6; b++) begin
			if (src[b] && lvl[b]) n_hi++;
			if (src[b] && !lvl[b]) n_lo++;
		end
		if (src[7:6] == 2'd0) return n_hi > 0;
		if (src[7:6] == 2'd1) return n_lo == 0;
		return 1'b0;  // reserved
	endfunction

	// returns {oe, out} for the three pins
	function automatic logic [5:0] drive_model(input cw_ioroute_t rt, input logic tx,
		input logic usi);
		logic [2:0] oe;
		logic [2:0] o;
		cw_byte_t r;
		for (int k = 0; k < 3; k++) begin
			r = rt[k*8 +: 8];
			{oe[k], o[k]} = 2'b00;
			if (r[0]) {oe[k], o[k]} = {1'b1, tx};
			else if (r[2]) {oe[k], o[k]} = {1'b1, usi};
			else if (k == 2 && r[4]) {oe[k], o[k]} = {!usi, 1'b0};  // open collector
			else if (r[7]) {oe[k], o[k]} = {1'b1, r[6]};
		end
		return {oe, o};
	endfunction

	function automatic logic pick_input(input cw_ioroute_t rt, input logic [2:0] pins,
		input int pos);
		for (int k = 0; k < 3; k++) begin
			if (rt[k*8 + pos]) return pins[k];  // lowest pin first
		end
		return 1'b1;
	endfunction

	always_comb begin
		exp_trig_ext = ext_model(shadow_trigsrc,
			{trig_io4_i, trig_io3_i, trig_io2_i, trig_io1_i, trig_fpb_i, trig_fpa_i});
		case (shadow_trigmod[2:0])
			3'd0: exp_trig = exp_trig_ext;
			3'd1: exp_trig = trig_advio_i;
			3'd2: exp_trig = trig_anapattern_i;
			default: exp_trig = 1'b0;
		endcase
		{exp_gpio_oe, exp_gpio} = drive_model(shadow_ioroute, uart_tx_i, usi_out_i);
		exp_uart_rx = pick_input(shadow_ioroute, gpio_i, ROUTE_RX);
		exp_usi_in  = pick_input(shadow_ioroute, gpio_i, ROUTE_USII);
		exp_hyplen  = hyplen_model(reg_hypaddress_i);
	end

	// read data is due after a read strobe, and 0 after an unqualified cycle
	always @(posedge clk) begin
		rd_chk_q <= reg_read_i || !reg_addrvalid_i;
		rd_exp_q <= (reg_addrvalid_i && addr_known(reg_address_i)) ?
			shadow_byte(reg_address_i, reg_bytecnt_i) : 8'h00;
	end

	function automatic void flag_mismatch(input string sig, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		err_cnt++;
		$display("ERR %s expected 0x%0h got 0x%0h", sig, exp_v, act_v);
	endfunction

	a_rdata: assert property (@(posedge clk) disable iff (reset)
		rd_chk_q |-> reg_datao_o === rd_exp_q)
		else flag_mismatch("reg_datao_o", $sampled(rd_exp_q), $sampled(reg_datao_o));
	a_hyplen: assert property (@(posedge clk) disable iff (reset) reg_hyplen_o === exp_hyplen)
		else flag_mismatch("reg_hyplen_o", $sampled(exp_hyplen), $sampled(reg_hyplen_o));
	a_trig_ext: assert property (@(posedge clk) disable iff (reset) trigger_ext_o === exp_trig_ext)
		else flag_mismatch("trigger_ext_o", $sampled(exp_trig_ext), $sampled(trigger_ext_o));
	a_trig: assert property (@(posedge clk) disable iff (reset) trigger_o === exp_trig)
		else flag_mismatch("trigger_o", $sampled(exp_trig), $sampled(trigger_o));
	a_gpio: assert property (@(posedge clk) disable iff (reset) gpio_o === exp_gpio)
		else flag_mismatch("gpio_o", $sampled(exp_gpio), $sampled(gpio_o));
	a_gpio_oe: assert property (@(posedge clk) disable iff (reset) gpio_oe_o === exp_gpio_oe)
		else flag_mismatch("gpio_oe_o", $sampled(exp_gpio_oe), $sampled(gpio_oe_o));
	a_uart_rx: assert property (@(posedge clk) disable iff (reset) uart_rx_o === exp_uart_rx)
		else flag_mismatch("uart_rx_o", $sampled(exp_uart_rx), $sampled(uart_rx_o));
	a_usi_in: assert property (@(posedge clk) disable iff (reset) usi_in_o === exp_usi_in)
		else flag_mismatch("usi_in_o", $sampled(exp_usi_in), $sampled(usi_in_o));

	task automatic drive_pins(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			{trig_io4_i, trig_io3_i, trig_io2_i, trig_io1_i, trig_fpb_i, trig_fpa_i} <= 6'($urandom);
			{trig_advio_i, trig_anapattern_i} <= 2'($urandom);
			{uart_tx_i, usi_out_i} <= 2'($urandom);
			gpio_i <= 3'($urandom);
		end
	endtask

	task automatic read_reset_values();
		drive_pins(8);  // GPIO1 carries tx, rx follows GPIO2
		bus_read(CW_TRIGSRC_ADDR, 16'd0, 1'b1);
		bus_read(CW_TRIGMOD_ADDR, 16'd0, 1'b1);
		for (int k = 0; k < CW_IOROUTE_BYTES; k++) bus_read(CW_IOROUTE_ADDR, cw_cnt_t'(k), 1'b1);
		test_done("reset");
	endtask

	task automatic write_read_back();
		bus_write(CW_TRIGSRC_ADDR, cw_cnt_t'($urandom), cw_byte_t'($urandom));
		bus_write(CW_TRIGMOD_ADDR, cw_cnt_t'($urandom), cw_byte_t'($urandom));
		for (int k = 0; k < 8; k++) begin
			bus_write(CW_IOROUTE_ADDR, cw_cnt_t'(($urandom << 3) | k), cw_byte_t'($urandom));
		end
		bus_read(CW_TRIGSRC_ADDR, 16'd0, 1'b1);
		bus_read(CW_TRIGMOD_ADDR, 16'd0, 1'b1);
		for (int k = 0; k < 8; k++) begin
			bus_read(CW_IOROUTE_ADDR, cw_cnt_t'(($urandom << 3) | k), 1'b1);
		end
		bus_read(unknown_addr(), 16'd0, 1'b1);    // unmapped reads 0
		bus_read(CW_TRIGSRC_ADDR, 16'd0, 1'b0);   // unqualified reads 0
		test_done("readback");
	endtask

	task automatic sweep_hyplen();
		@(posedge clk) reg_hypaddress_i <= CW_TRIGSRC_ADDR;
		@(posedge clk) reg_hypaddress_i <= CW_TRIGMOD_ADDR;
		@(posedge clk) reg_hypaddress_i <= CW_IOROUTE_ADDR;
		repeat (8) @(posedge clk) reg_hypaddress_i <= unknown_addr();
		test_done("length");
	endtask

	task automatic combine_triggers();
		for (int mode = 0; mode < 4; mode++) begin
			for (int sel = 0; sel < 6; sel++) begin
				// empty mask on the last pass of each mode, a reserved select
				bus_write(CW_TRIGSRC_ADDR, 16'd0, {mode[1:0], (sel == 5) ? 6'd0 : 6'($urandom)});
				bus_write(CW_TRIGMOD_ADDR, 16'd0, {5'($urandom), sel[2:0]});
				drive_pins(3);
			end
		end
		test_done("trigger");
	endtask

	task automatic route_gpio_pins();
		cw_byte_t pin3;
		for (int it = 0; it < 24; it++) begin
			pin3 = cw_byte_t'($urandom);
			if (it % 3 == 0) pin3 = (pin3 & 8'hfa) | 8'h10;  // force the open collector path
			bus_write(CW_IOROUTE_ADDR, 16'd0, cw_byte_t'($urandom));
			bus_write(CW_IOROUTE_ADDR, 16'd1, cw_byte_t'($urandom));
			bus_write(CW_IOROUTE_ADDR, 16'd2, pin3);
			drive_pins(4);
		end
		test_done("gpio");
	endtask

	initial begin
		void'($urandom(32'he861));
		reset = 1'b1;
		{reg_address_i, reg_bytecnt_i, reg_datai_i, reg_hypaddress_i} = '0;
		{reg_read_i, reg_write_i, reg_addrvalid_i} = 3'b000;
		{trig_fpa_i, trig_fpb_i, trig_io1_i, trig_io2_i, trig_io3_i, trig_io4_i} = 6'd0;
		{trig_advio_i, trig_anapattern_i, uart_tx_i, usi_out_i} = 4'd0;
		gpio_i = 3'd0;
		shadow_trigsrc = 8'h01;
		shadow_trigmod = 8'h00;
		shadow_ioroute = 64'h0201;  // tx on GPIO1, rx on GPIO2
		{err_cnt, err_mark, test_cnt} = '0;
		repeat (RESET_CYC) @(posedge clk);
		reset <= 1'b0;
		read_reset_values();
		write_read_back();
		sweep_hyplen();
		combine_triggers();
		route_gpio_pins();
		$display("tests run %0d, errors %0d", test_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// watchdog at twice the summed test budgets
	initial begin
		#(2 * TOTAL_CYC * CLK_PERIOD);
		$display("timeout, the tests did not finish within %0d cycles", 2 * TOTAL_CYC);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- files.f
+incdir+dv
rtl/cw_pkg.sv
rtl/cw_regfile.sv
rtl/trig_combine.sv
rtl/target_io_route.sv
rtl/cw_route_top.sv
dv/cw_route_tb.sv
